// File: common/dsp_pkg.sv
package dsp_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int sample_width   = 16;
	localparam int n_blocks       = 16;
	localparam int n_registers    = 16;
	localparam int n_delays       = 4;
	localparam int n_sram_banks   = 4;
	localparam int sram_bank_size = 256;
	localparam int sram_capacity  = 1024;
	localparam int lut_depth      = 32;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic signed [sample_width - 1:0] sample_t;
	typedef logic [$clog2(n_blocks) - 1:0] block_addr_t;
	typedef logic [$clog2(n_registers) - 1:0] reg_addr_t;
	// One extra bit so the capacity itself is representable.
	typedef logic [$clog2(sram_capacity + 1) - 1:0] sram_addr_t;
	typedef logic [$clog2(n_delays) - 1:0] delay_id_t;

	typedef enum logic [2:0] {
		op_nop   = 3'd0,
		op_gain  = 3'd1,
		op_add   = 3'd2,
		op_lut   = 3'd3,
		op_delay = 3'd4,
		op_end   = 3'd5
	} opcode_t;

	typedef enum logic [1:0] {
		seq_ready,
		seq_processing,
		seq_invalid
	} seq_state_t;

	// Operand is a register index, or a delay id in its low bits.
	typedef struct packed {
		opcode_t op;
		logic [3:0] operand;
	} instr_t;

	typedef struct packed {
		logic req;
		sample_t arg;
	} lut_req_t;

	typedef struct packed {
		logic read;
		logic write;
		delay_id_t id;
		sample_t data;
	} delay_req_t;

	typedef struct packed {
		logic read;
		logic write;
		sram_addr_t read_addr;
		sram_addr_t write_addr;
		sample_t data;
	} sram_req_t;

endpackage

// File: logic/lut_master.sv
`timescale 1ns/1ns

module lut_master (
	input logic clk,
	input logic reset,
	input dsp_pkg::lut_req_t req,
	output dsp_pkg::sample_t data_out,
	output logic ready
);
	dsp_pkg::sample_t table_mem [dsp_pkg::lut_depth];
	logic [$clog2(dsp_pkg::lut_depth) - 1:0] index;
	logic stage;

	// Soft-clip curve.
	initial begin
		$readmemh("lut_table.mem", table_mem);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage <= 1'b0;
			ready <= 1'b0;
		end else begin
			stage <= req.req;
			ready <= stage;
		end
	end

	// Top bits of the argument with the sign flipped, so entry 0 is the most negative input.
	always_ff @(posedge clk) begin
		if (req.req)
			index <= req.arg[dsp_pkg::sample_width - 1 -: $clog2(dsp_pkg::lut_depth)]
				^ {1'b1, {($clog2(dsp_pkg::lut_depth) - 1){1'b0}}};
		if (stage)
			data_out <= table_mem[index];
	end

endmodule

// File: delay/contiguous_sram.sv
`timescale 1ns/1ns

module contiguous_sram (
	input logic clk,
	input logic reset,
	input dsp_pkg::sram_req_t req,
	output dsp_pkg::sample_t data_out,
	output logic read_ready,
	output logic write_ready,
	output logic invalid_read,
	output logic invalid_write
);
	dsp_pkg::sample_t banks [dsp_pkg::n_sram_banks][dsp_pkg::sram_bank_size];
	logic [$clog2(dsp_pkg::n_sram_banks) - 1:0] read_bank;
	logic [$clog2(dsp_pkg::n_sram_banks) - 1:0] write_bank;
	logic [$clog2(dsp_pkg::sram_bank_size) - 1:0] read_word;
	logic [$clog2(dsp_pkg::sram_bank_size) - 1:0] write_word;
	logic read_ok;
	logic write_ok;

	// Upper address bits pick the bank, lower bits the word.
	assign read_bank  = req.read_addr[$clog2(dsp_pkg::sram_bank_size) +: $clog2(dsp_pkg::n_sram_banks)];
	assign read_word  = req.read_addr[$clog2(dsp_pkg::sram_bank_size) - 1:0];
	assign write_bank = req.write_addr[$clog2(dsp_pkg::sram_bank_size) +: $clog2(dsp_pkg::n_sram_banks)];
	assign write_word = req.write_addr[$clog2(dsp_pkg::sram_bank_size) - 1:0];
	assign read_ok    = (req.read_addr < dsp_pkg::sram_capacity);
	assign write_ok   = (req.write_addr < dsp_pkg::sram_capacity);

	always_ff @(posedge clk) begin
		if (req.write && write_ok)
			banks[write_bank][write_word] <= req.data;
		if (req.read && read_ok)
			data_out <= banks[read_bank][read_word];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_ready    <= 1'b0;
			write_ready   <= 1'b0;
			invalid_read  <= 1'b0;
			invalid_write <= 1'b0;
		end else begin
			read_ready    <= req.read && read_ok;
			write_ready   <= req.write && write_ok;
			invalid_read  <= req.read && !read_ok;
			invalid_write <= req.write && !write_ok;
		end
	end

endmodule

// File: delay/delay_master.sv
`timescale 1ns/1ns

module delay_master (
	input logic clk,
	input logic reset,
	input dsp_pkg::delay_req_t req,
	input logic alloc,
	input dsp_pkg::sram_addr_t alloc_size,
	output dsp_pkg::sample_t data_out,
	output logic ready,
	output dsp_pkg::sram_req_t sram,
	input dsp_pkg::sample_t sram_data,
	input logic sram_read_ready,
	input logic sram_write_ready,
	output logic invalid
);
	typedef enum logic [1:0] {d_idle, d_read, d_write} delay_state_t;

	delay_state_t state;
	dsp_pkg::sram_addr_t base [dsp_pkg::n_delays];
	dsp_pkg::sram_addr_t size [dsp_pkg::n_delays];
	dsp_pkg::sram_addr_t ptr [dsp_pkg::n_delays];
	dsp_pkg::sram_addr_t fill [dsp_pkg::n_delays];
	logic [dsp_pkg::n_delays - 1:0] valid;
	dsp_pkg::sram_addr_t cursor;
	logic [$clog2(dsp_pkg::n_delays + 1) - 1:0] alloc_count;
	dsp_pkg::delay_id_t alloc_id;
	logic [$bits(dsp_pkg::sram_addr_t):0] alloc_end;
	logic alloc_ok;
	dsp_pkg::delay_id_t cur_id;
	dsp_pkg::sample_t cur_data;
	logic cur_write;
	dsp_pkg::sample_t read_val;
	logic filled;

	assign alloc_id  = alloc_count[$bits(dsp_pkg::delay_id_t) - 1:0];
	assign alloc_end = cursor + alloc_size;
	assign alloc_ok  = (alloc_count < dsp_pkg::n_delays) && (alloc_size != '0)
		&& (alloc_end <= dsp_pkg::sram_capacity);
	assign filled    = (fill[cur_id] >= size[cur_id]);

	// Read the oldest slot first, then overwrite it with the new sample.
	always_comb begin
		sram            = '0;
		sram.read       = (state == d_idle) && req.read && valid[req.id];
		sram.read_addr  = base[req.id] + ptr[req.id];
		sram.write      = (state == d_read) && sram_read_ready && cur_write;
		sram.write_addr = base[cur_id] + ptr[cur_id];
		sram.data       = cur_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= d_idle;
			valid       <= '0;
			cursor      <= '0;
			alloc_count <= '0;
			ready       <= 1'b0;
			invalid     <= 1'b0;
		end else begin
			ready   <= 1'b0;
			invalid <= 1'b0;

			// Regions are handed out back to back.
			if (alloc) begin
				if (alloc_ok) begin
					base[alloc_id]  <= cursor;
					size[alloc_id]  <= alloc_size;
					ptr[alloc_id]   <= '0;
					fill[alloc_id]  <= '0;
					valid[alloc_id] <= 1'b1;
					cursor          <= cursor + alloc_size;
					alloc_count     <= alloc_count + 1'b1;
				end else begin
					invalid <= 1'b1;
				end
			end

			case (state)
				d_idle: begin
					if (req.read && valid[req.id]) begin
						cur_id    <= req.id;
						cur_data  <= req.data;
						cur_write <= req.write;
						state     <= d_read;
					end else if (req.read) begin
						invalid  <= 1'b1;
						ready    <= 1'b1;
						data_out <= '0;
					end
				end
				d_read: begin
					if (sram_read_ready) begin
						if (cur_write) begin
							read_val <= sram_data;
							state    <= d_write;
						end else begin
							ready    <= 1'b1;
							data_out <= filled ? sram_data : '0;
							state    <= d_idle;
						end
					end
				end
				d_write: begin
					if (sram_write_ready) begin
						ready    <= 1'b1;
						data_out <= filled ? read_val : '0;
						ptr[cur_id] <= (ptr[cur_id] + 1'b1 == size[cur_id]) ? '0 : ptr[cur_id] + 1'b1;
						if (!filled)
							fill[cur_id] <= fill[cur_id] + 1'b1;
						state <= d_idle;
					end
				end
				default: state <= d_idle;
			endcase
		end
	end

endmodule

// File: dsp_core/dsp_core.sv
`timescale 1ns/1ns

module dsp_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input dsp_pkg::sample_t sample_in,
	output dsp_pkg::sample_t sample_out,
	output logic ready,
	input logic instr_write,
	input logic reg_write,
	input dsp_pkg::block_addr_t block_target,
	input dsp_pkg::reg_addr_t reg_target,
	input dsp_pkg::instr_t instr_val,
	input dsp_pkg::sample_t reg_val,
	output logic instr_write_ack,
	output logic reg_write_ack,
	output dsp_pkg::lut_req_t lut,
	input dsp_pkg::sample_t lut_data,
	input logic lut_ready,
	output dsp_pkg::delay_req_t delay,
	input dsp_pkg::sample_t delay_data,
	input logic delay_ready,
	output logic bad_instr
);
	typedef enum logic [1:0] {core_idle, core_run, core_wait_lut, core_wait_delay} core_state_t;

	core_state_t state;
	dsp_pkg::instr_t program_mem [dsp_pkg::n_blocks];
	dsp_pkg::sample_t regs [dsp_pkg::n_registers];
	dsp_pkg::block_addr_t pc;
	dsp_pkg::sample_t acc;
	dsp_pkg::instr_t cur;
	dsp_pkg::sample_t operand_val;
	logic signed [31:0] product;
	logic signed [31:0] sum_wide;
	dsp_pkg::sample_t result;
	logic step;
	logic stop;
	logic illegal;
	logic last_slot;

	// Clamp a wide value to the sample range.
	function automatic dsp_pkg::sample_t saturate(input logic signed [31:0] value);
		if (value[31:dsp_pkg::sample_width - 1] == '0 || value[31:dsp_pkg::sample_width - 1] == '1)
			return value[dsp_pkg::sample_width - 1:0];
		else if (value[31])
			return {1'b1, {(dsp_pkg::sample_width - 1){1'b0}}};
		else
			return {1'b0, {(dsp_pkg::sample_width - 1){1'b1}}};
	endfunction

	assign cur         = program_mem[pc];
	assign operand_val = regs[dsp_pkg::reg_addr_t'(cur.operand)];
	assign product     = acc * operand_val;
	assign sum_wide    = acc + operand_val;
	assign last_slot   = (pc == dsp_pkg::block_addr_t'(dsp_pkg::n_blocks - 1));
	assign sample_out  = acc;

	assign lut   = '{req: (state == core_run && cur.op == dsp_pkg::op_lut), arg: acc};
	assign delay = '{
		read:  (state == core_run && cur.op == dsp_pkg::op_delay),
		write: (state == core_run && cur.op == dsp_pkg::op_delay),
		id:    cur.operand[$bits(dsp_pkg::delay_id_t) - 1:0],
		data:  acc
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Block execution.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		step    = 1'b0;
		stop    = 1'b0;
		illegal = 1'b0;
		result  = acc;
		case (state)
			core_run: begin
				case (cur.op)
					dsp_pkg::op_nop: step = 1'b1;
					dsp_pkg::op_gain: begin
						// Q8.8 multiply.
						step   = 1'b1;
						result = saturate(product >>> 8);
					end
					dsp_pkg::op_add: begin
						step   = 1'b1;
						result = saturate(sum_wide);
					end
					dsp_pkg::op_lut, dsp_pkg::op_delay: step = 1'b0;
					dsp_pkg::op_end: stop = 1'b1;
					default: begin
						stop    = 1'b1;
						illegal = 1'b1;
					end
				endcase
			end
			core_wait_lut: begin
				if (lut_ready) begin
					step   = 1'b1;
					result = lut_data;
				end
			end
			core_wait_delay: begin
				if (delay_ready) begin
					step   = 1'b1;
					result = delay_data;
				end
			end
			default: step = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= core_idle;
			pc        <= '0;
			ready     <= 1'b1;
			bad_instr <= 1'b0;
		end else begin
			bad_instr <= illegal;
			if (state == core_idle) begin
				if (tick) begin
					pc    <= '0;
					ready <= 1'b0;
					state <= core_run;
				end
			end else if (stop || (step && last_slot)) begin
				ready <= 1'b1;
				state <= core_idle;
			end else if (step) begin
				pc    <= pc + 1'b1;
				state <= core_run;
			end else if (state == core_run) begin
				state <= (cur.op == dsp_pkg::op_lut) ? core_wait_lut : core_wait_delay;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_idle) begin
			if (tick)
				acc <= sample_in;
		end else begin
			acc <= result;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host writes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dsp_pkg::n_blocks; i++)
				program_mem[i] <= '{op: dsp_pkg::op_end, operand: '0};
			for (int i = 0; i < dsp_pkg::n_registers; i++)
				regs[i] <= '0;
			instr_write_ack <= 1'b0;
			reg_write_ack   <= 1'b0;
		end else begin
			instr_write_ack <= instr_write;
			reg_write_ack   <= reg_write;
			if (instr_write)
				program_mem[block_target] <= instr_val;
			if (reg_write)
				regs[reg_target] <= reg_val;
		end
	end

endmodule

// File: logic/pipeline_seq.sv
`timescale 1ns/1ns

module pipeline_seq (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dsp_pkg::sample_t in_sample,
	output dsp_pkg::sample_t out_sample,
	output logic ready,
	output logic error,
	input dsp_pkg::block_addr_t block_target,
	input dsp_pkg::reg_addr_t reg_target,
	input dsp_pkg::instr_t instr_val,
	input logic instr_write,
	input logic reg_write,
	input logic alloc_sram_delay,
	input dsp_pkg::sample_t ctrl_data,
	output logic reg_write_ack,
	output logic instr_write_ack
);
	dsp_pkg::seq_state_t state;
	logic wait_one;
	logic tick;
	logic core_ready;
	logic bad_instr;
	logic fault;

	dsp_pkg::lut_req_t lut_req;
	dsp_pkg::sample_t lut_data;
	logic lut_ready;

	dsp_pkg::delay_req_t delay_req;
	dsp_pkg::sample_t delay_data;
	logic delay_ready;
	logic delay_invalid;
	dsp_pkg::sram_addr_t alloc_size;

	dsp_pkg::sram_req_t sram_req;
	dsp_pkg::sample_t sram_data;
	logic sram_read_ready;
	logic sram_write_ready;
	logic sram_invalid_read;
	logic sram_invalid_write;

	assign ready = (state == dsp_pkg::seq_ready);
	assign tick  = in_valid && ready;
	assign fault = bad_instr || delay_invalid || sram_invalid_read || sram_invalid_write;

	// Sizes that do not fit the address width saturate, so they fail the range check.
	assign alloc_size = (ctrl_data[dsp_pkg::sample_width - 1:$bits(dsp_pkg::sram_addr_t)] != '0)
		? '1 : ctrl_data[$bits(dsp_pkg::sram_addr_t) - 1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= dsp_pkg::seq_ready;
			wait_one <= 1'b0;
			error    <= 1'b0;
		end else begin
			wait_one <= 1'b0;
			case (state)
				dsp_pkg::seq_ready: begin
					if (in_valid) begin
						state    <= dsp_pkg::seq_processing;
						wait_one <= 1'b1;
					end
				end
				dsp_pkg::seq_processing: begin
					// A new sample while busy is a protocol error.
					if (in_valid)
						state <= dsp_pkg::seq_invalid;
					else if (!wait_one && core_ready)
						state <= dsp_pkg::seq_ready;
				end
				dsp_pkg::seq_invalid: begin
					state <= dsp_pkg::seq_invalid;
				end
				default: begin
					state <= dsp_pkg::seq_invalid;
				end
			endcase
			if (fault)
				state <= dsp_pkg::seq_invalid;
			if (fault || !(state inside {dsp_pkg::seq_ready, dsp_pkg::seq_processing}))
				error <= 1'b1;
		end
	end

	dsp_core core (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(in_sample),
		.sample_out(out_sample),
		.ready(core_ready),
		.instr_write(instr_write),
		.reg_write(reg_write),
		.block_target(block_target),
		.reg_target(reg_target),
		.instr_val(instr_val),
		.reg_val(ctrl_data),
		.instr_write_ack(instr_write_ack),
		.reg_write_ack(reg_write_ack),
		.lut(lut_req),
		.lut_data(lut_data),
		.lut_ready(lut_ready),
		.delay(delay_req),
		.delay_data(delay_data),
		.delay_ready(delay_ready),
		.bad_instr(bad_instr)
	);

	lut_master luts (
		.clk(clk),
		.reset(reset),
		.req(lut_req),
		.data_out(lut_data),
		.ready(lut_ready)
	);

	delay_master delays (
		.clk(clk),
		.reset(reset),
		.req(delay_req),
		.alloc(alloc_sram_delay),
		.alloc_size(alloc_size),
		.data_out(delay_data),
		.ready(delay_ready),
		.sram(sram_req),
		.sram_data(sram_data),
		.sram_read_ready(sram_read_ready),
		.sram_write_ready(sram_write_ready),
		.invalid(delay_invalid)
	);

	contiguous_sram sram (
		.clk(clk),
		.reset(reset),
		.req(sram_req),
		.data_out(sram_data),
		.read_ready(sram_read_ready),
		.write_ready(sram_write_ready),
		.invalid_read(sram_invalid_read),
		.invalid_write(sram_invalid_write)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	input logic restart,
	output logic clk,
	output logic reset
);
	localparam int half_period = 50;
	localparam int drive_delay = 10;
	localparam int reset_cycles = 2;

	// Rising edges still to come with reset high, besides the current one.
	int hold;

	initial begin
		clk   = 1'b0;
		reset = 1'b1;
		hold  = reset_cycles - 1;
	end

	always #half_period clk = ~clk;

	// Reset moves with the other inputs, just after the rising edge.
	always @(posedge clk) begin
		if (restart)
			hold = reset_cycles;
		#drive_delay;
		reset = (hold != 0);
		if (hold != 0)
			hold--;
	end

endmodule

// File: tests/pipeline_tb.sv
`timescale 1ns/1ns

module pipeline_tb;

	localparam int drive_delay = 10;
	localparam int sample_budget = 70;
	// About 50 samples at the longest program, plus host writes and resets.
	localparam int cycle_limit = 50 * sample_budget + 500;
	localparam int delay_a = 3;
	localparam int delay_b = 5;

	logic clk;
	logic reset;
	logic restart;
	logic in_valid;
	dsp_pkg::sample_t in_sample;
	dsp_pkg::sample_t out_sample;
	logic ready;
	logic error;
	dsp_pkg::block_addr_t block_target;
	dsp_pkg::reg_addr_t reg_target;
	dsp_pkg::instr_t instr_val;
	logic instr_write;
	logic reg_write;
	logic alloc_sram_delay;
	dsp_pkg::sample_t ctrl_data;
	logic reg_write_ack;
	logic instr_write_ack;

	dsp_pkg::sample_t lut_ref [dsp_pkg::lut_depth];
	dsp_pkg::sample_t history [$];
	logic [16:0] lfsr;
	string test_name;
	int cycles = 0;
	int test_errors = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock clock_gen (.restart(restart), .clk(clk), .reset(reset));

	pipeline_seq pipeline_seq_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_sample(in_sample),
		.out_sample(out_sample),
		.ready(ready),
		.error(error),
		.block_target(block_target),
		.reg_target(reg_target),
		.instr_val(instr_val),
		.instr_write(instr_write),
		.reg_write(reg_write),
		.alloc_sram_delay(alloc_sram_delay),
		.ctrl_data(ctrl_data),
		.reg_write_ack(reg_write_ack),
		.instr_write_ack(instr_write_ack)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 17-bit Fibonacci LFSR with taps 17 and 14, stepped once per bit.
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
			value = {value[14:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic dsp_pkg::sample_t clamp(input int value);
		if (value > 32767)
			return 16'sh7fff;
		else if (value < -32768)
			return 16'sh8000;
		else
			return dsp_pkg::sample_t'(value);
	endfunction

	function automatic dsp_pkg::sample_t gain_add_model(input dsp_pkg::sample_t x,
			input dsp_pkg::sample_t g, input dsp_pkg::sample_t a);
		int scaled;
		scaled = (int'(x) * int'(g)) >>> 8;
		return clamp(int'(clamp(scaled)) + int'(a));
	endfunction

	// Sign bit flipped, so the most negative input lands on entry 0.
	function automatic dsp_pkg::sample_t lut_model(input dsp_pkg::sample_t x);
		return lut_ref[{~x[15], x[14:11]}];
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Driving and checking.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic fail_check(input string what);
		$display("ERROR in %s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic check_sample(input dsp_pkg::sample_t expected, input dsp_pkg::sample_t actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s: expected %0d, actual %0d", test_name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, test_errors);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	task automatic apply_reset();
		restart = 1'b1;
		next_cycle();
		restart = 1'b0;
		@(negedge reset);
	endtask

	task automatic write_instr(input int slot, input dsp_pkg::opcode_t op, input int operand);
		block_target      = dsp_pkg::block_addr_t'(slot);
		instr_val.op      = op;
		instr_val.operand = 4'(operand);
		instr_write       = 1'b1;
		next_cycle();
		instr_write = 1'b0;
		assert (instr_write_ack === 1'b1) else fail_check("instruction write got no ack");
		next_cycle();
		assert (instr_write_ack === 1'b0) else fail_check("instruction ack lasted two cycles");
	endtask

	task automatic write_reg(input int index, input dsp_pkg::sample_t value);
		reg_target = dsp_pkg::reg_addr_t'(index);
		ctrl_data  = value;
		reg_write  = 1'b1;
		next_cycle();
		reg_write = 1'b0;
		assert (reg_write_ack === 1'b1) else fail_check("register write got no ack");
		next_cycle();
		assert (reg_write_ack === 1'b0) else fail_check("register ack lasted two cycles");
	endtask

	task automatic allocate(input int size);
		ctrl_data        = dsp_pkg::sample_t'(size);
		alloc_sram_delay = 1'b1;
		next_cycle();
		alloc_sram_delay = 1'b0;
	endtask

	task automatic run_sample(input dsp_pkg::sample_t value, output dsp_pkg::sample_t result);
		int waited;
		in_sample = value;
		in_valid  = 1'b1;
		next_cycle();
		in_valid = 1'b0;
		waited   = 0;
		assert (!ready) else fail_check("ready stayed high after a sample was taken");
		while (!ready && waited < sample_budget) begin
			next_cycle();
			waited++;
		end
		assert (ready) else fail_check("ready did not come back after a sample");
		result = out_sample;
	endtask

	// Error must rise soon and then hold ready low.
	task automatic check_locked(input string cause);
		int waited;
		waited = 0;
		while (!error && waited < 8) begin
			next_cycle();
			waited++;
		end
		assert (error) else fail_check({cause, " did not raise error"});
		repeat (4) begin
			next_cycle();
			assert (!ready && error) else fail_check({cause, " did not keep ready low"});
		end
	endtask

	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("FAIL: see errors above");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		dsp_pkg::sample_t got;
		dsp_pkg::sample_t x;
		dsp_pkg::sample_t g;
		dsp_pkg::sample_t a;
		int n;

		restart          = 1'b0;
		in_valid         = 1'b0;
		in_sample        = '0;
		block_target     = '0;
		reg_target       = '0;
		instr_val        = '0;
		instr_write      = 1'b0;
		reg_write        = 1'b0;
		alloc_sram_delay = 1'b0;
		ctrl_data        = '0;
		lfsr             = 17'd79690;
		$readmemh("lut_table.mem", lut_ref);
		@(negedge reset);

		start_test("reset_state");
		assert (ready === 1'b1) else fail_check("ready is not high after reset");
		assert (error === 1'b0) else fail_check("error is set after reset");
		assert (instr_write_ack === 1'b0 && reg_write_ack === 1'b0)
			else fail_check("an ack is high after reset");
		write_instr(0, dsp_pkg::op_end, 0);
		write_reg(0, 16'sh0000);
		finish_test();

		start_test("gain_add");
		write_instr(0, dsp_pkg::op_gain, 1);
		write_instr(1, dsp_pkg::op_add, 2);
		write_instr(2, dsp_pkg::op_end, 0);
		for (int i = 0; i < 16; i++) begin
			g = random_bits(16);
			a = random_bits(16);
			x = random_bits(16);
			// The last four land on the saturation limits.
			case (i)
				12: begin
					g = 16'sh7fff;
					a = 16'sh7fff;
					x = 16'sh7fff;
				end
				13: begin
					g = 16'sh7fff;
					a = 16'sh8000;
					x = 16'sh8000;
				end
				14: begin
					g = 16'sh0100;
					a = 16'sh7fff;
					x = 16'sh0001;
				end
				15: begin
					g = 16'sh0100;
					a = 16'sh8000;
					x = 16'shffff;
				end
				default: ;
			endcase
			write_reg(1, g);
			write_reg(2, a);
			run_sample(x, got);
			check_sample(gain_add_model(x, g, a), got);
		end
		finish_test();

		start_test("lut");
		write_instr(0, dsp_pkg::op_lut, 0);
		write_instr(1, dsp_pkg::op_end, 0);
		for (int i = 0; i < 16; i++) begin
			x = random_bits(16);
			run_sample(x, got);
			check_sample(lut_model(x), got);
		end
		finish_test();

		start_test("program_flow");
		write_instr(0, dsp_pkg::op_end, 0);
		for (int i = 0; i < 2; i++) begin
			x = random_bits(16);
			run_sample(x, got);
			check_sample(x, got);
		end
		// A full program of nops runs off the end of slot 15.
		for (int i = 0; i < dsp_pkg::n_blocks; i++)
			write_instr(i, dsp_pkg::op_nop, 0);
		for (int i = 0; i < 2; i++) begin
			x = random_bits(16);
			run_sample(x, got);
			check_sample(x, got);
		end
		finish_test();

		start_test("delay");
		allocate(delay_a);
		allocate(delay_b);
		write_instr(0, dsp_pkg::op_delay, 0);
		write_instr(1, dsp_pkg::op_delay, 1);
		write_instr(2, dsp_pkg::op_end, 0);
		history.delete();
		for (int i = 0; i < 12; i++) begin
			x = random_bits(16);
			history.push_back(x);
			n = history.size() - 1;
			run_sample(x, got);
			if (n >= delay_a + delay_b)
				check_sample(history[n - delay_a - delay_b], got);
			else
				check_sample(16'sh0000, got);
		end
		assert (!error) else fail_check("error rose during delay processing");
		finish_test();

		start_test("errors");
		apply_reset();
		allocate(2000);
		check_locked("oversized allocation");
		apply_reset();
		write_instr(0, dsp_pkg::op_delay, 2);
		write_instr(1, dsp_pkg::op_end, 0);
		in_sample = random_bits(16);
		in_valid  = 1'b1;
		next_cycle();
		in_valid = 1'b0;
		check_locked("delay on unallocated id");
		apply_reset();
		assert (ready && !error) else fail_check("reset did not clear the error");
		finish_test();

		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: lut_table.mem
// One signed 16-bit entry per line, hex, for table index 0 to 31.
// Index 0 is the most negative input; the curve is 1.5x - 0.5x^3 scaled to full range.
8000
80BC
82E0
8654
8B00
90CC
97A0
9F64
A800
B15C
BB60
C5F4
D100
DC6C
E820
F404
0000
0BFC
17E0
2394
2F00
3A0C
44A0
4EA4
5800
609C
6860
6F34
7500
79AC
7D20
7F44

// File: verilog.f
common/dsp_pkg.sv
logic/lut_master.sv
delay/contiguous_sram.sv
delay/delay_master.sv
dsp_core/dsp_core.sv
logic/pipeline_seq.sv
tests/tb_clock.sv
tests/pipeline_tb.sv

// File: Makefile
# Verilator build and run for the DSP pipeline testbench.

VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The table file is read relative to the project root.
run: compile
	./$(BINARY) | tee $(LOG)
	grep -Fxq "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
